/* verilog/trace_pkg.sv */
package trace_pkg;

  // Instruction and register data width
  localparam int instr_width_c = 32;

  localparam int reg_addr_width_c = 5;

  // Tile coordinate widths
  localparam int x_cord_width_c = 6;
  localparam int y_cord_width_c = 5;

  localparam int seq_width_c = 16;
  localparam int stamp_width_c = 32;

  // pc_plus4 of zero minus four
  localparam logic [instr_width_c-1:0] bubble_pc_c = {{(instr_width_c-2){1'b1}}, 2'b00};

  // Stall reasons, listed from highest priority down
  typedef enum logic [2:0] {
    stall_none,
    stall_ifetch,
    stall_idiv_wb,
    stall_remote_ld_wb,
    stall_fdiv_wb,
    stall_remote_flw_wb
  } stall_reason_e;

  // Memory access kind of an instruction
  typedef enum logic [2:0] {
    access_none,
    access_local_load,
    access_local_store,
    access_remote_load,
    access_remote_store
  } mem_access_e;

endpackage

/* verilog/trace_stage_pipe.sv */
module trace_stage_pipe
  import trace_pkg::*;
  #(parameter int pc_width_p = 22
    , parameter int dmem_addr_width_p = 10
  )
  (
    input clk_i
    , input reset_i
    , input stall_all_i

    , input [instr_width_c-1:0] exe_pc_plus4_i
    , input [instr_width_c-1:0] exe_instr_i
    , input exe_is_branch_i
    , input exe_is_jal_i
    , input exe_is_jalr_i
    , input [pc_width_p-1:0] pc_n_i

    , input dmem_v_i
    , input dmem_w_i
    , input [dmem_addr_width_p-1:0] dmem_addr_i
    , input [instr_width_c-1:0] dmem_wdata_i
    , input [instr_width_c-1:0] dmem_rdata_i

    , input remote_v_i
    , input remote_write_i
    , input remote_icache_fetch_i
    , input [instr_width_c-1:0] remote_addr_i
    , input [instr_width_c-1:0] remote_data_i

    , output logic [instr_width_c-1:0] wb_pc_o
    , output logic [instr_width_c-1:0] wb_instr_o
    , output logic wb_bt_v_o
    , output logic [instr_width_c-1:0] wb_btarget_o
    , output mem_access_e wb_access_o
    , output logic [dmem_addr_width_p-1:0] wb_dmem_addr_o
    , output logic [instr_width_c-1:0] wb_remote_addr_o
    , output logic [instr_width_c-1:0] wb_access_data_o
  );

  logic [instr_width_c-1:0] exe_pc;
  logic exe_bt_v;
  logic [instr_width_c-1:0] exe_btarget;
  mem_access_e exe_access;
  logic [instr_width_c-1:0] exe_store_data;

  logic [instr_width_c-1:0] mem_pc_r;
  logic [instr_width_c-1:0] mem_instr_r;
  logic mem_bt_v_r;
  logic [instr_width_c-1:0] mem_btarget_r;
  mem_access_e mem_access_r;
  logic [dmem_addr_width_p-1:0] mem_dmem_addr_r;
  logic [instr_width_c-1:0] mem_remote_addr_r;
  logic [instr_width_c-1:0] mem_store_data_r;

  logic [instr_width_c-1:0] wb_access_data;

  assign exe_pc = exe_pc_plus4_i - instr_width_c'(4);
  assign exe_bt_v = exe_is_branch_i | exe_is_jal_i | exe_is_jalr_i;
  // Word address back to byte address
  assign exe_btarget = {{(instr_width_c-2-pc_width_p){1'b0}}, pc_n_i, 2'b00};

  // Local traffic wins over remote, stores over loads on the network side
  always_comb begin
    exe_access = access_none;
    if (dmem_v_i & ~dmem_w_i) begin
      exe_access = access_local_load;
    end else if (dmem_v_i & dmem_w_i) begin
      exe_access = access_local_store;
    end else if (remote_v_i & remote_write_i) begin
      exe_access = access_remote_store;
    end else if (remote_v_i & ~remote_icache_fetch_i) begin
      exe_access = access_remote_load;
    end
  end

  always_comb begin
    case (exe_access)
      access_local_store:  exe_store_data = dmem_wdata_i;
      access_remote_store: exe_store_data = remote_data_i;
      default:             exe_store_data = '0;
    endcase
  end

  // Load data arrives during MEM
  always_comb begin
    case (mem_access_r)
      access_local_load:   wb_access_data = dmem_rdata_i;
      access_local_store,
      access_remote_store: wb_access_data = mem_store_data_r;
      default:             wb_access_data = '0;
    endcase
  end

  // Both stages start as bubbles
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mem_pc_r <= bubble_pc_c;
      mem_instr_r <= '0;
      mem_bt_v_r <= 1'b0;
      mem_btarget_r <= '0;
      mem_access_r <= access_none;
      mem_dmem_addr_r <= '0;
      mem_remote_addr_r <= '0;
      mem_store_data_r <= '0;
      wb_pc_o <= bubble_pc_c;
      wb_instr_o <= '0;
      wb_bt_v_o <= 1'b0;
      wb_btarget_o <= '0;
      wb_access_o <= access_none;
      wb_dmem_addr_o <= '0;
      wb_remote_addr_o <= '0;
      wb_access_data_o <= '0;
    end else if (~stall_all_i) begin
      mem_pc_r <= exe_pc;
      mem_instr_r <= exe_instr_i;
      mem_bt_v_r <= exe_bt_v;
      mem_btarget_r <= exe_btarget;
      mem_access_r <= exe_access;
      mem_dmem_addr_r <= dmem_addr_i;
      mem_remote_addr_r <= remote_addr_i;
      mem_store_data_r <= exe_store_data;
      wb_pc_o <= mem_pc_r;
      wb_instr_o <= mem_instr_r;
      wb_bt_v_o <= mem_bt_v_r;
      wb_btarget_o <= mem_btarget_r;
      wb_access_o <= mem_access_r;
      wb_dmem_addr_o <= mem_dmem_addr_r;
      wb_remote_addr_o <= mem_remote_addr_r;
      wb_access_data_o <= wb_access_data;
    end
  end

endmodule

/* verilog/trace_event_observer.sv */
module trace_event_observer
  import trace_pkg::*;
  (
    input clk_i
    , input reset_i

    , input stall_ifetch_i
    , input stall_idiv_wb_i
    , input stall_remote_ld_wb_i
    , input stall_fdiv_wb_i
    , input stall_remote_flw_wb_i

    , input int_wen_i
    , input [reg_addr_width_c-1:0] int_waddr_i
    , input [instr_width_c-1:0] int_wdata_i

    , input fp_wen_i
    , input [reg_addr_width_c-1:0] fp_waddr_i
    , input [instr_width_c-1:0] fp_wdata_i

    , output stall_reason_e stall_reason_o
    , output logic int_wen_o
    , output logic [reg_addr_width_c-1:0] int_waddr_o
    , output logic [instr_width_c-1:0] int_wdata_o
    , output logic fp_wen_o
    , output logic [reg_addr_width_c-1:0] fp_waddr_o
    , output logic [instr_width_c-1:0] fp_wdata_o
    , output logic [stamp_width_c-1:0] stamp_o
  );

  // Fetch stall hides any writeback stall
  always_comb begin
    if (stall_ifetch_i) begin
      stall_reason_o = stall_ifetch;
    end else if (stall_idiv_wb_i) begin
      stall_reason_o = stall_idiv_wb;
    end else if (stall_remote_ld_wb_i) begin
      stall_reason_o = stall_remote_ld_wb;
    end else if (stall_fdiv_wb_i) begin
      stall_reason_o = stall_fdiv_wb;
    end else if (stall_remote_flw_wb_i) begin
      stall_reason_o = stall_remote_flw_wb;
    end else begin
      stall_reason_o = stall_none;
    end
  end

  // Idle write ports show up as zero
  assign int_wen_o = int_wen_i;
  assign int_waddr_o = int_wen_i ? int_waddr_i : '0;
  assign int_wdata_o = int_wen_i ? int_wdata_i : '0;

  // Float data stays in raw form
  assign fp_wen_o = fp_wen_i;
  assign fp_waddr_o = fp_wen_i ? fp_waddr_i : '0;
  assign fp_wdata_o = fp_wen_i ? fp_wdata_i : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stamp_o <= '0;
    end else begin
      stamp_o <= stamp_o + 1'b1;
    end
  end

endmodule

/* verilog/trace_record_builder.sv */
module trace_record_builder
  import trace_pkg::*;
  #(parameter int pc_width_p = 22
    , parameter int dmem_addr_width_p = 10
  )
  (
    input clk_i
    , input reset_i
    , input trace_en_i

    , input [x_cord_width_c-1:0] my_x_i
    , input [y_cord_width_c-1:0] my_y_i

    , input [instr_width_c-1:0] wb_pc_i
    , input [instr_width_c-1:0] wb_instr_i
    , input wb_bt_v_i
    , input [instr_width_c-1:0] wb_btarget_i
    , input mem_access_e wb_access_i
    , input [dmem_addr_width_p-1:0] wb_dmem_addr_i
    , input [instr_width_c-1:0] wb_remote_addr_i
    , input [instr_width_c-1:0] wb_access_data_i

    , input stall_reason_e stall_reason_i
    , input int_wen_i
    , input [reg_addr_width_c-1:0] int_waddr_i
    , input [instr_width_c-1:0] int_wdata_i
    , input fp_wen_i
    , input [reg_addr_width_c-1:0] fp_waddr_i
    , input [instr_width_c-1:0] fp_wdata_i
    , input [stamp_width_c-1:0] stamp_i

    , output logic trace_v_o
    , output logic [seq_width_c-1:0] trace_seq_o
    , output logic [stamp_width_c-1:0] trace_stamp_o
    , output logic [x_cord_width_c-1:0] trace_x_o
    , output logic [y_cord_width_c-1:0] trace_y_o
    , output logic trace_bubble_o
    , output logic [instr_width_c-1:0] trace_pc_o
    , output logic [instr_width_c-1:0] trace_instr_o
    , output stall_reason_e trace_stall_o
    , output logic trace_int_wen_o
    , output logic [reg_addr_width_c-1:0] trace_int_waddr_o
    , output logic [instr_width_c-1:0] trace_int_wdata_o
    , output logic trace_fp_v_o
    , output logic [reg_addr_width_c-1:0] trace_fp_waddr_o
    , output logic [instr_width_c-1:0] trace_fp_wdata_o
    , output logic trace_bt_v_o
    , output logic [instr_width_c-1:0] trace_btarget_o
    , output mem_access_e trace_access_o
    , output logic [dmem_addr_width_p-1:0] trace_dmem_addr_o
    , output logic [instr_width_c-1:0] trace_remote_addr_o
    , output logic [instr_width_c-1:0] trace_access_data_o
  );

  // Byte-address bits a branch target can actually use
  localparam int btarget_width_lp = pc_width_p + 2;

  logic wb_bubble;
  logic [seq_width_c-1:0] seq_cnt_r;
  logic [btarget_width_lp-1:0] btarget_r;

  assign wb_bubble = (wb_pc_i == bubble_pc_c);

  // Upper target bits are always zero
  assign trace_btarget_o = {{(instr_width_c-btarget_width_lp){1'b0}}, btarget_r};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      trace_v_o <= 1'b0;
      trace_seq_o <= '0;
      trace_stamp_o <= '0;
      seq_cnt_r <= '0;
    end else begin
      trace_v_o <= trace_en_i;
      if (trace_en_i) begin
        trace_seq_o <= seq_cnt_r;
        trace_stamp_o <= stamp_i;
        seq_cnt_r <= seq_cnt_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (trace_en_i) begin
      trace_x_o <= my_x_i;
      trace_y_o <= my_y_i;
      trace_bubble_o <= wb_bubble;
      trace_pc_o <= wb_pc_i;
      trace_instr_o <= wb_instr_i;
      trace_stall_o <= stall_reason_i;
      trace_int_wen_o <= int_wen_i;
      trace_int_waddr_o <= int_waddr_i;
      trace_int_wdata_o <= int_wdata_i;
      // No float record for a bubble
      trace_fp_v_o <= fp_wen_i & ~wb_bubble;
      trace_fp_waddr_o <= fp_waddr_i;
      trace_fp_wdata_o <= fp_wdata_i;
      trace_bt_v_o <= wb_bt_v_i;
      btarget_r <= wb_btarget_i[btarget_width_lp-1:0];
      trace_access_o <= wb_access_i;
      trace_dmem_addr_o <= wb_dmem_addr_i;
      trace_remote_addr_o <= wb_remote_addr_i;
      trace_access_data_o <= wb_access_data_i;
    end
  end

endmodule

/* verilog/core_trace_top.sv */
module core_trace_top
  import trace_pkg::*;
  #(parameter int pc_width_p = 22
    , parameter int dmem_addr_width_p = 10
  )
  (
    input clk_i
    , input reset_i
    , input trace_en_i

    , input stall_all_i
    , input stall_ifetch_i
    , input stall_idiv_wb_i
    , input stall_remote_ld_wb_i
    , input stall_fdiv_wb_i
    , input stall_remote_flw_wb_i

    , input [instr_width_c-1:0] exe_pc_plus4_i
    , input [instr_width_c-1:0] exe_instr_i
    , input exe_is_branch_i
    , input exe_is_jal_i
    , input exe_is_jalr_i
    , input [pc_width_p-1:0] pc_n_i

    , input dmem_v_i
    , input dmem_w_i
    , input [dmem_addr_width_p-1:0] dmem_addr_i
    , input [instr_width_c-1:0] dmem_wdata_i
    , input [instr_width_c-1:0] dmem_rdata_i

    , input remote_v_i
    , input remote_write_i
    , input remote_icache_fetch_i
    , input [instr_width_c-1:0] remote_addr_i
    , input [instr_width_c-1:0] remote_data_i

    , input int_wen_i
    , input [reg_addr_width_c-1:0] int_waddr_i
    , input [instr_width_c-1:0] int_wdata_i
    , input fp_wen_i
    , input [reg_addr_width_c-1:0] fp_waddr_i
    , input [instr_width_c-1:0] fp_wdata_i

    , input [x_cord_width_c-1:0] my_x_i
    , input [y_cord_width_c-1:0] my_y_i

    , output logic trace_v_o
    , output logic [seq_width_c-1:0] trace_seq_o
    , output logic [stamp_width_c-1:0] trace_stamp_o
    , output logic [x_cord_width_c-1:0] trace_x_o
    , output logic [y_cord_width_c-1:0] trace_y_o
    , output logic trace_bubble_o
    , output logic [instr_width_c-1:0] trace_pc_o
    , output logic [instr_width_c-1:0] trace_instr_o
    , output stall_reason_e trace_stall_o
    , output logic trace_int_wen_o
    , output logic [reg_addr_width_c-1:0] trace_int_waddr_o
    , output logic [instr_width_c-1:0] trace_int_wdata_o
    , output logic trace_fp_v_o
    , output logic [reg_addr_width_c-1:0] trace_fp_waddr_o
    , output logic [instr_width_c-1:0] trace_fp_wdata_o
    , output logic trace_bt_v_o
    , output logic [instr_width_c-1:0] trace_btarget_o
    , output mem_access_e trace_access_o
    , output logic [dmem_addr_width_p-1:0] trace_dmem_addr_o
    , output logic [instr_width_c-1:0] trace_remote_addr_o
    , output logic [instr_width_c-1:0] trace_access_data_o
  );

  // WB shadow state
  logic [instr_width_c-1:0] wb_pc;
  logic [instr_width_c-1:0] wb_instr;
  logic wb_bt_v;
  logic [instr_width_c-1:0] wb_btarget;
  mem_access_e wb_access;
  logic [dmem_addr_width_p-1:0] wb_dmem_addr;
  logic [instr_width_c-1:0] wb_remote_addr;
  logic [instr_width_c-1:0] wb_access_data;

  // Observer events
  stall_reason_e stall_reason;
  logic int_wen;
  logic [reg_addr_width_c-1:0] int_waddr;
  logic [instr_width_c-1:0] int_wdata;
  logic fp_wen;
  logic [reg_addr_width_c-1:0] fp_waddr;
  logic [instr_width_c-1:0] fp_wdata;
  logic [stamp_width_c-1:0] stamp;

  trace_stage_pipe #(
    .pc_width_p(pc_width_p)
    , .dmem_addr_width_p(dmem_addr_width_p)
  ) u_stage_pipe (
    .clk_i(clk_i)
    , .reset_i(reset_i)
    , .stall_all_i(stall_all_i)
    , .exe_pc_plus4_i(exe_pc_plus4_i)
    , .exe_instr_i(exe_instr_i)
    , .exe_is_branch_i(exe_is_branch_i)
    , .exe_is_jal_i(exe_is_jal_i)
    , .exe_is_jalr_i(exe_is_jalr_i)
    , .pc_n_i(pc_n_i)
    , .dmem_v_i(dmem_v_i)
    , .dmem_w_i(dmem_w_i)
    , .dmem_addr_i(dmem_addr_i)
    , .dmem_wdata_i(dmem_wdata_i)
    , .dmem_rdata_i(dmem_rdata_i)
    , .remote_v_i(remote_v_i)
    , .remote_write_i(remote_write_i)
    , .remote_icache_fetch_i(remote_icache_fetch_i)
    , .remote_addr_i(remote_addr_i)
    , .remote_data_i(remote_data_i)
    , .wb_pc_o(wb_pc)
    , .wb_instr_o(wb_instr)
    , .wb_bt_v_o(wb_bt_v)
    , .wb_btarget_o(wb_btarget)
    , .wb_access_o(wb_access)
    , .wb_dmem_addr_o(wb_dmem_addr)
    , .wb_remote_addr_o(wb_remote_addr)
    , .wb_access_data_o(wb_access_data)
  );

  trace_event_observer u_event_observer (
    .clk_i(clk_i)
    , .reset_i(reset_i)
    , .stall_ifetch_i(stall_ifetch_i)
    , .stall_idiv_wb_i(stall_idiv_wb_i)
    , .stall_remote_ld_wb_i(stall_remote_ld_wb_i)
    , .stall_fdiv_wb_i(stall_fdiv_wb_i)
    , .stall_remote_flw_wb_i(stall_remote_flw_wb_i)
    , .int_wen_i(int_wen_i)
    , .int_waddr_i(int_waddr_i)
    , .int_wdata_i(int_wdata_i)
    , .fp_wen_i(fp_wen_i)
    , .fp_waddr_i(fp_waddr_i)
    , .fp_wdata_i(fp_wdata_i)
    , .stall_reason_o(stall_reason)
    , .int_wen_o(int_wen)
    , .int_waddr_o(int_waddr)
    , .int_wdata_o(int_wdata)
    , .fp_wen_o(fp_wen)
    , .fp_waddr_o(fp_waddr)
    , .fp_wdata_o(fp_wdata)
    , .stamp_o(stamp)
  );

  trace_record_builder #(
    .pc_width_p(pc_width_p)
    , .dmem_addr_width_p(dmem_addr_width_p)
  ) u_record_builder (
    .clk_i(clk_i)
    , .reset_i(reset_i)
    , .trace_en_i(trace_en_i)
    , .my_x_i(my_x_i)
    , .my_y_i(my_y_i)
    , .wb_pc_i(wb_pc)
    , .wb_instr_i(wb_instr)
    , .wb_bt_v_i(wb_bt_v)
    , .wb_btarget_i(wb_btarget)
    , .wb_access_i(wb_access)
    , .wb_dmem_addr_i(wb_dmem_addr)
    , .wb_remote_addr_i(wb_remote_addr)
    , .wb_access_data_i(wb_access_data)
    , .stall_reason_i(stall_reason)
    , .int_wen_i(int_wen)
    , .int_waddr_i(int_waddr)
    , .int_wdata_i(int_wdata)
    , .fp_wen_i(fp_wen)
    , .fp_waddr_i(fp_waddr)
    , .fp_wdata_i(fp_wdata)
    , .stamp_i(stamp)
    , .trace_v_o(trace_v_o)
    , .trace_seq_o(trace_seq_o)
    , .trace_stamp_o(trace_stamp_o)
    , .trace_x_o(trace_x_o)
    , .trace_y_o(trace_y_o)
    , .trace_bubble_o(trace_bubble_o)
    , .trace_pc_o(trace_pc_o)
    , .trace_instr_o(trace_instr_o)
    , .trace_stall_o(trace_stall_o)
    , .trace_int_wen_o(trace_int_wen_o)
    , .trace_int_waddr_o(trace_int_waddr_o)
    , .trace_int_wdata_o(trace_int_wdata_o)
    , .trace_fp_v_o(trace_fp_v_o)
    , .trace_fp_waddr_o(trace_fp_waddr_o)
    , .trace_fp_wdata_o(trace_fp_wdata_o)
    , .trace_bt_v_o(trace_bt_v_o)
    , .trace_btarget_o(trace_btarget_o)
    , .trace_access_o(trace_access_o)
    , .trace_dmem_addr_o(trace_dmem_addr_o)
    , .trace_remote_addr_o(trace_remote_addr_o)
    , .trace_access_data_o(trace_access_data_o)
  );

endmodule

/* dv/core_trace_sva.sv */
module core_trace_sva
  import trace_pkg::*;
  #(parameter int pc_width_p = 22
    , parameter int dmem_addr_width_p = 10
  )
  (
    input clk_i
    , input reset_i
    , input trace_en_i
    , input stall_all_i
    , input stall_ifetch_i
    , input stall_idiv_wb_i
    , input stall_remote_ld_wb_i
    , input stall_fdiv_wb_i
    , input stall_remote_flw_wb_i
    , input [instr_width_c-1:0] exe_pc_plus4_i
    , input [instr_width_c-1:0] exe_instr_i
    , input exe_is_branch_i
    , input exe_is_jal_i
    , input exe_is_jalr_i
    , input [pc_width_p-1:0] pc_n_i
    , input dmem_v_i
    , input dmem_w_i
    , input [dmem_addr_width_p-1:0] dmem_addr_i
    , input [instr_width_c-1:0] dmem_wdata_i
    , input [instr_width_c-1:0] dmem_rdata_i
    , input remote_v_i
    , input remote_write_i
    , input remote_icache_fetch_i
    , input [instr_width_c-1:0] remote_addr_i
    , input [instr_width_c-1:0] remote_data_i
    , input int_wen_i
    , input [reg_addr_width_c-1:0] int_waddr_i
    , input [instr_width_c-1:0] int_wdata_i
    , input fp_wen_i
    , input [reg_addr_width_c-1:0] fp_waddr_i
    , input [instr_width_c-1:0] fp_wdata_i
    , input [x_cord_width_c-1:0] my_x_i
    , input [y_cord_width_c-1:0] my_y_i
    , input trace_v_o
    , input [seq_width_c-1:0] trace_seq_o
    , input [stamp_width_c-1:0] trace_stamp_o
    , input [x_cord_width_c-1:0] trace_x_o
    , input [y_cord_width_c-1:0] trace_y_o
    , input trace_bubble_o
    , input [instr_width_c-1:0] trace_pc_o
    , input [instr_width_c-1:0] trace_instr_o
    , input stall_reason_e trace_stall_o
    , input trace_int_wen_o
    , input [reg_addr_width_c-1:0] trace_int_waddr_o
    , input [instr_width_c-1:0] trace_int_wdata_o
    , input trace_fp_v_o
    , input [reg_addr_width_c-1:0] trace_fp_waddr_o
    , input [instr_width_c-1:0] trace_fp_wdata_o
    , input trace_bt_v_o
    , input [instr_width_c-1:0] trace_btarget_o
    , input mem_access_e trace_access_o
    , input [dmem_addr_width_p-1:0] trace_dmem_addr_o
    , input [instr_width_c-1:0] trace_remote_addr_o
    , input [instr_width_c-1:0] trace_access_data_o
  );

  // Flags in order ifetch, idiv, remote ld, fdiv, remote flw
  function automatic stall_reason_e stall_priority(input logic [4:0] flags);
    casez (flags)
      5'b1????: return stall_ifetch;
      5'b01???: return stall_idiv_wb;
      5'b001??: return stall_remote_ld_wb;
      5'b0001?: return stall_fdiv_wb;
      5'b00001: return stall_remote_flw_wb;
      default:  return stall_none;
    endcase
  endfunction

  function automatic mem_access_e access_kind(input logic dv, input logic dw,
                                              input logic rv, input logic rw,
                                              input logic rf);
    if (dv) begin
      return dw ? access_local_store : access_local_load;
    end
    if (rv && rw) begin
      return access_remote_store;
    end
    if (rv && !rf) begin
      return access_remote_load;
    end
    return access_none;
  endfunction

  mem_access_e exe_kind;
  logic [instr_width_c-1:0] exe_store;

  logic [instr_width_c-1:0] mem_pc_r, mem_instr_r, mem_btarget_r, mem_raddr_r, mem_store_r;
  logic mem_bt_v_r;
  mem_access_e mem_kind_r;
  logic [dmem_addr_width_p-1:0] mem_daddr_r;
  logic [instr_width_c-1:0] wb_pc_r, wb_instr_r, wb_btarget_r, wb_raddr_r, wb_data_r;
  logic wb_bt_v_r;
  mem_access_e wb_kind_r;
  logic [dmem_addr_width_p-1:0] wb_daddr_r;
  logic [stamp_width_c-1:0] stamp_r;
  logic [seq_width_c-1:0] seq_r;

  // Expected record
  logic rec_seen_r, exp_v_r, exp_bubble_r, exp_bt_v_r, exp_int_wen_r, exp_fp_v_r;
  logic [seq_width_c-1:0] exp_seq_r;
  logic [stamp_width_c-1:0] exp_stamp_r;
  logic [instr_width_c-1:0] exp_pc_r, exp_instr_r, exp_btarget_r, exp_raddr_r, exp_data_r;
  logic [instr_width_c-1:0] exp_int_wdata_r, exp_fp_wdata_r;
  logic [reg_addr_width_c-1:0] exp_int_waddr_r, exp_fp_waddr_r;
  logic [dmem_addr_width_p-1:0] exp_daddr_r;
  logic [x_cord_width_c-1:0] exp_x_r;
  logic [y_cord_width_c-1:0] exp_y_r;
  stall_reason_e exp_stall_r;
  mem_access_e exp_kind_r;

  logic fail_reset = 1'b0;
  logic fail_valid = 1'b0;
  logic fail_count = 1'b0;
  logic fail_pc = 1'b0;
  logic fail_ctrl = 1'b0;
  logic fail_access = 1'b0;
  logic fail_stall = 1'b0;
  logic fail_int = 1'b0;
  logic fail_fp = 1'b0;
  logic fail_tile = 1'b0;
  logic failed;

  assign failed = fail_reset | fail_valid | fail_count | fail_pc | fail_ctrl
                  | fail_access | fail_stall | fail_int | fail_fp | fail_tile;

  assign exe_kind = access_kind(dmem_v_i, dmem_w_i, remote_v_i, remote_write_i,
                                remote_icache_fetch_i);
  assign exe_store = (exe_kind == access_local_store) ? dmem_wdata_i
                   : (exe_kind == access_remote_store) ? remote_data_i : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mem_pc_r <= bubble_pc_c;
      mem_instr_r <= '0;
      mem_bt_v_r <= 1'b0;
      mem_btarget_r <= '0;
      mem_kind_r <= access_none;
      mem_daddr_r <= '0;
      mem_raddr_r <= '0;
      mem_store_r <= '0;
      wb_pc_r <= bubble_pc_c;
      wb_instr_r <= '0;
      wb_bt_v_r <= 1'b0;
      wb_btarget_r <= '0;
      wb_kind_r <= access_none;
      wb_daddr_r <= '0;
      wb_raddr_r <= '0;
      wb_data_r <= '0;
      stamp_r <= '0;
      seq_r <= '0;
      rec_seen_r <= 1'b0;
      exp_v_r <= 1'b0;
      exp_seq_r <= '0;
      exp_stamp_r <= '0;
    end else begin
      stamp_r <= stamp_r + 1;
      exp_v_r <= trace_en_i;
      if (trace_en_i) begin
        rec_seen_r <= 1'b1;
        seq_r <= seq_r + 1;
        exp_seq_r <= seq_r;
        exp_stamp_r <= stamp_r;
        exp_pc_r <= wb_pc_r;
        exp_bubble_r <= (wb_pc_r == bubble_pc_c);
        exp_instr_r <= wb_instr_r;
        exp_bt_v_r <= wb_bt_v_r;
        exp_btarget_r <= wb_btarget_r;
        exp_kind_r <= wb_kind_r;
        exp_daddr_r <= wb_daddr_r;
        exp_raddr_r <= wb_raddr_r;
        exp_data_r <= wb_data_r;
        exp_stall_r <= stall_priority({stall_ifetch_i, stall_idiv_wb_i, stall_remote_ld_wb_i,
                                       stall_fdiv_wb_i, stall_remote_flw_wb_i});
        exp_int_wen_r <= int_wen_i;
        exp_int_waddr_r <= int_wen_i ? int_waddr_i : '0;
        exp_int_wdata_r <= int_wen_i ? int_wdata_i : '0;
        exp_fp_v_r <= fp_wen_i && (wb_pc_r != bubble_pc_c);
        exp_fp_waddr_r <= fp_wen_i ? fp_waddr_i : '0;
        exp_fp_wdata_r <= fp_wen_i ? fp_wdata_i : '0;
        exp_x_r <= my_x_i;
        exp_y_r <= my_y_i;
      end
      if (!stall_all_i) begin
        mem_pc_r <= exe_pc_plus4_i - 32'd4;
        mem_instr_r <= exe_instr_i;
        mem_bt_v_r <= exe_is_branch_i || exe_is_jal_i || exe_is_jalr_i;
        mem_btarget_r <= instr_width_c'(pc_n_i) << 2;
        mem_kind_r <= exe_kind;
        mem_daddr_r <= dmem_addr_i;
        mem_raddr_r <= remote_addr_i;
        mem_store_r <= exe_store;
        wb_pc_r <= mem_pc_r;
        wb_instr_r <= mem_instr_r;
        wb_bt_v_r <= mem_bt_v_r;
        wb_btarget_r <= mem_btarget_r;
        wb_kind_r <= mem_kind_r;
        wb_daddr_r <= mem_daddr_r;
        wb_raddr_r <= mem_raddr_r;
        // Load data is taken as the load leaves MEM
        wb_data_r <= (mem_kind_r == access_local_load) ? dmem_rdata_i : mem_store_r;
      end
    end
  end

  a_reset: assert property (@(posedge clk_i) disable iff (reset_i)
    $past(reset_i) |-> (!trace_v_o && trace_seq_o == '0 && trace_stamp_o == '0))
    else begin
      fail_reset = 1'b1;
      $error("error after reset trace_v_o %h trace_seq_o %h trace_stamp_o %h expected 0",
             $sampled(trace_v_o), $sampled(trace_seq_o), $sampled(trace_stamp_o));
    end

  a_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    trace_v_o == exp_v_r)
    else begin
      fail_valid = 1'b1;
      $error("error trace_v_o %h expected %h", $sampled(trace_v_o), $sampled(exp_v_r));
    end

  a_count: assert property (@(posedge clk_i) disable iff (reset_i)
    trace_seq_o == exp_seq_r && trace_stamp_o == exp_stamp_r)
    else begin
      fail_count = 1'b1;
      $error("error trace_seq_o %h expected %h, trace_stamp_o %h expected %h",
             $sampled(trace_seq_o), $sampled(exp_seq_r),
             $sampled(trace_stamp_o), $sampled(exp_stamp_r));
    end

  a_pc: assert property (@(posedge clk_i) disable iff (reset_i)
    rec_seen_r |-> (trace_pc_o == exp_pc_r && trace_bubble_o == exp_bubble_r))
    else begin
      fail_pc = 1'b1;
      $error("error trace_pc_o %h expected %h, trace_bubble_o %h expected %h",
             $sampled(trace_pc_o), $sampled(exp_pc_r),
             $sampled(trace_bubble_o), $sampled(exp_bubble_r));
    end

  a_ctrl: assert property (@(posedge clk_i) disable iff (reset_i)
    rec_seen_r |-> (trace_instr_o == exp_instr_r && trace_bt_v_o == exp_bt_v_r
                    && trace_btarget_o == exp_btarget_r))
    else begin
      fail_ctrl = 1'b1;
      $error("error trace_instr_o %h/%h trace_bt_v_o %h/%h trace_btarget_o %h/%h",
             $sampled(trace_instr_o), $sampled(exp_instr_r), $sampled(trace_bt_v_o),
             $sampled(exp_bt_v_r), $sampled(trace_btarget_o), $sampled(exp_btarget_r));
    end

  a_access: assert property (@(posedge clk_i) disable iff (reset_i)
    rec_seen_r |-> (trace_access_o == exp_kind_r && trace_access_data_o == exp_data_r
                    && trace_dmem_addr_o == exp_daddr_r
                    && trace_remote_addr_o == exp_raddr_r))
    else begin
      fail_access = 1'b1;
      $error("error trace_access_o %h/%h trace_access_data_o %h/%h addr %h/%h %h/%h",
             $sampled(trace_access_o), $sampled(exp_kind_r),
             $sampled(trace_access_data_o), $sampled(exp_data_r),
             $sampled(trace_dmem_addr_o), $sampled(exp_daddr_r),
             $sampled(trace_remote_addr_o), $sampled(exp_raddr_r));
    end

  a_stall: assert property (@(posedge clk_i) disable iff (reset_i)
    rec_seen_r |-> trace_stall_o == exp_stall_r)
    else begin
      fail_stall = 1'b1;
      $error("error trace_stall_o %h expected %h", $sampled(trace_stall_o),
             $sampled(exp_stall_r));
    end

  a_int: assert property (@(posedge clk_i) disable iff (reset_i)
    rec_seen_r |-> (trace_int_wen_o == exp_int_wen_r && trace_int_waddr_o == exp_int_waddr_r
                    && trace_int_wdata_o == exp_int_wdata_r))
    else begin
      fail_int = 1'b1;
      $error("error trace_int_wen_o %h/%h trace_int_waddr_o %h/%h trace_int_wdata_o %h/%h",
             $sampled(trace_int_wen_o), $sampled(exp_int_wen_r),
             $sampled(trace_int_waddr_o), $sampled(exp_int_waddr_r),
             $sampled(trace_int_wdata_o), $sampled(exp_int_wdata_r));
    end

  a_fp: assert property (@(posedge clk_i) disable iff (reset_i)
    rec_seen_r |-> (trace_fp_v_o == exp_fp_v_r && trace_fp_waddr_o == exp_fp_waddr_r
                    && trace_fp_wdata_o == exp_fp_wdata_r))
    else begin
      fail_fp = 1'b1;
      $error("error trace_fp_v_o %h/%h trace_fp_waddr_o %h/%h trace_fp_wdata_o %h/%h",
             $sampled(trace_fp_v_o), $sampled(exp_fp_v_r),
             $sampled(trace_fp_waddr_o), $sampled(exp_fp_waddr_r),
             $sampled(trace_fp_wdata_o), $sampled(exp_fp_wdata_r));
    end

  a_tile: assert property (@(posedge clk_i) disable iff (reset_i)
    rec_seen_r |-> (trace_x_o == exp_x_r && trace_y_o == exp_y_r))
    else begin
      fail_tile = 1'b1;
      $error("error trace_x_o %h expected %h, trace_y_o %h expected %h",
             $sampled(trace_x_o), $sampled(exp_x_r), $sampled(trace_y_o), $sampled(exp_y_r));
    end

endmodule

bind core_trace_top core_trace_sva #(
  .pc_width_p(pc_width_p)
  , .dmem_addr_width_p(dmem_addr_width_p)
) u_core_trace_sva (.*);

/* dv/core_trace_tb.sv */
module core_trace_tb
  import trace_pkg::*;
  ();

  localparam int pc_width_lp = 22;
  localparam int dmem_addr_width_lp = 10;
  localparam int clk_period_lp = 8;
  localparam int reset_cycles_lp = 4;
  localparam int num_cycles_lp = 2000;
  localparam int timeout_cycles_lp = reset_cycles_lp + num_cycles_lp + 96;

  logic clk_i, reset_i, trace_en_i;
  logic stall_all_i, stall_ifetch_i, stall_idiv_wb_i, stall_remote_ld_wb_i;
  logic stall_fdiv_wb_i, stall_remote_flw_wb_i;
  logic [instr_width_c-1:0] exe_pc_plus4_i, exe_instr_i;
  logic exe_is_branch_i, exe_is_jal_i, exe_is_jalr_i;
  logic [pc_width_lp-1:0] pc_n_i;
  logic dmem_v_i, dmem_w_i;
  logic [dmem_addr_width_lp-1:0] dmem_addr_i;
  logic [instr_width_c-1:0] dmem_wdata_i, dmem_rdata_i;
  logic remote_v_i, remote_write_i, remote_icache_fetch_i;
  logic [instr_width_c-1:0] remote_addr_i, remote_data_i;
  logic int_wen_i, fp_wen_i;
  logic [reg_addr_width_c-1:0] int_waddr_i, fp_waddr_i;
  logic [instr_width_c-1:0] int_wdata_i, fp_wdata_i;
  logic [x_cord_width_c-1:0] my_x_i;
  logic [y_cord_width_c-1:0] my_y_i;

  logic trace_v_o, trace_bubble_o, trace_int_wen_o, trace_fp_v_o, trace_bt_v_o;
  logic [seq_width_c-1:0] trace_seq_o;
  logic [stamp_width_c-1:0] trace_stamp_o;
  logic [x_cord_width_c-1:0] trace_x_o;
  logic [y_cord_width_c-1:0] trace_y_o;
  logic [instr_width_c-1:0] trace_pc_o, trace_instr_o, trace_btarget_o;
  logic [instr_width_c-1:0] trace_int_wdata_o, trace_fp_wdata_o;
  logic [instr_width_c-1:0] trace_remote_addr_o, trace_access_data_o;
  logic [reg_addr_width_c-1:0] trace_int_waddr_o, trace_fp_waddr_o;
  logic [dmem_addr_width_lp-1:0] trace_dmem_addr_o;
  stall_reason_e trace_stall_o;
  mem_access_e trace_access_o;

  logic assertion_failed;
  int en_run_left;

  core_trace_top #(
    .pc_width_p(pc_width_lp)
    , .dmem_addr_width_p(dmem_addr_width_lp)
  ) u_core_trace_top (.*);

  assign assertion_failed = u_core_trace_top.u_core_trace_sva.failed;

  initial begin
    clk_i = 1'b0;
    forever #(clk_period_lp / 2) clk_i = ~clk_i;
  end

  // Long traced runs broken by short gaps
  task automatic drive_trace_enable();
    if (en_run_left == 0) begin
      if (trace_en_i) begin
        trace_en_i <= 1'b0;
        en_run_left = 1 + ($urandom % 4);
      end else begin
        trace_en_i <= 1'b1;
        en_run_left = 20 + ($urandom % 40);
      end
    end else begin
      en_run_left = en_run_left - 1;
    end
  endtask

  task automatic drive_random_inputs();
    stall_all_i <= ($urandom % 4) == 0;
    stall_ifetch_i <= ($urandom % 4) == 0;
    stall_idiv_wb_i <= ($urandom % 4) == 0;
    stall_remote_ld_wb_i <= ($urandom % 4) == 0;
    stall_fdiv_wb_i <= ($urandom % 4) == 0;
    stall_remote_flw_wb_i <= ($urandom % 4) == 0;
    exe_pc_plus4_i <= (($urandom % 8) == 0) ? '0 : $urandom;
    exe_instr_i <= $urandom;
    exe_is_branch_i <= ($urandom % 8) == 0;
    exe_is_jal_i <= ($urandom % 8) == 0;
    exe_is_jalr_i <= ($urandom % 8) == 0;
    pc_n_i <= $urandom;
    dmem_v_i <= $urandom % 2;
    dmem_w_i <= $urandom % 2;
    dmem_addr_i <= $urandom;
    dmem_wdata_i <= $urandom;
    dmem_rdata_i <= $urandom;
    remote_v_i <= $urandom % 2;
    remote_write_i <= $urandom % 2;
    remote_icache_fetch_i <= $urandom % 2;
    remote_addr_i <= $urandom;
    remote_data_i <= $urandom;
    int_wen_i <= $urandom % 2;
    int_waddr_i <= $urandom;
    int_wdata_i <= $urandom;
    fp_wen_i <= $urandom % 2;
    fp_waddr_i <= $urandom;
    fp_wdata_i <= $urandom;
    my_x_i <= $urandom;
    my_y_i <= $urandom;
    drive_trace_enable();
  endtask

  initial begin
    void'($urandom(32'hafe9_3d77));
    en_run_left = 0;
    reset_i = 1'b1;
    trace_en_i = 1'b0;
    {stall_all_i, stall_ifetch_i, stall_idiv_wb_i, stall_remote_ld_wb_i} = '0;
    {stall_fdiv_wb_i, stall_remote_flw_wb_i} = '0;
    {exe_pc_plus4_i, exe_instr_i, pc_n_i} = '0;
    {exe_is_branch_i, exe_is_jal_i, exe_is_jalr_i} = '0;
    {dmem_v_i, dmem_w_i, dmem_addr_i, dmem_wdata_i, dmem_rdata_i} = '0;
    {remote_v_i, remote_write_i, remote_icache_fetch_i, remote_addr_i, remote_data_i} = '0;
    {int_wen_i, int_waddr_i, int_wdata_i, fp_wen_i, fp_waddr_i, fp_wdata_i} = '0;
    {my_x_i, my_y_i} = '0;

    repeat (reset_cycles_lp) @(posedge clk_i);
    reset_i <= 1'b0;
    repeat (num_cycles_lp) begin
      @(posedge clk_i);
      drive_random_inputs();
    end
    repeat (4) @(posedge clk_i);

    if (assertion_failed) begin
      $display("Test failed");
      $fatal(1, "a trace record check failed");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

  // Stop at the first failed check
  initial begin
    wait (assertion_failed === 1'b1);
    $display("Test failed");
    $fatal(1, "a trace record check failed");
  end

  initial begin
    #(timeout_cycles_lp * clk_period_lp);
    $display("Test failed");
    $fatal(1, "timeout, the run did not finish within %0d cycles", timeout_cycles_lp);
  end

endmodule

/* project.f */
verilog/trace_pkg.sv
verilog/trace_stage_pipe.sv
verilog/trace_event_observer.sv
verilog/trace_record_builder.sv
verilog/core_trace_top.sv
dv/core_trace_sva.sv
dv/core_trace_tb.sv

/* Bender.yml */
package:
  name: core_trace

sources:
  - verilog/trace_pkg.sv
  - verilog/trace_stage_pipe.sv
  - verilog/trace_event_observer.sv
  - verilog/trace_record_builder.sv
  - verilog/core_trace_top.sv
  - target: simulation
    files:
      - dv/core_trace_sva.sv
      - dv/core_trace_tb.sv
